//--- rv_core_test.hex
// One 32-bit RV32I instruction word per line, in address order from 0x00
// Trailing comments give the byte address and the assembly
000100b7 // 00 lui   x1, 0x10
ff008093 // 04 addi  x1, x1, -16       io port 0xfff0
02900113 // 08 addi  x2, x0, 0x29
00210133 // 0c add   x2, x2, x2        0x52
0020a023 // 10 sw    x2, 0(x1)         'R'
00410193 // 14 addi  x3, x2, 4         0x56
00300293 // 18 addi  x5, x0, 3         loop count
03000213 // 1c addi  x4, x0, 0x30
0030a023 // 20 sw    x3, 0(x1)         'V'
00120213 // 24 addi  x4, x4, 1         loop head
fff28293 // 28 addi  x5, x5, -1
fe029ce3 // 2c bne   x5, x0, 0x24
0040a023 // 30 sw    x4, 0(x1)         '3'
fff20313 // 34 addi  x6, x4, -1        0x32
10602023 // 38 sw    x6, 0x100(x0)
10002383 // 3c lw    x7, 0x100(x0)
03c0046f // 40 jal   x8, 0x7c          call
0070a023 // 44 sw    x7, 0(x1)         '2'
00100693 // 48 addi  x13, x0, 1
00569693 // 4c slli  x13, x13, 5       0x20
0090a023 // 50 sw    x9, 0(x1)         'I'
0064e593 // 54 ori   x11, x9, 6        0x4f
0045c613 // 58 xori  x12, x11, 4       0x4b
00d0a023 // 5c sw    x13, 0(x1)        ' '
00c5f7b3 // 60 and   x15, x11, x12     0x4b
00b63733 // 64 sltu  x14, x12, x11     1
00b0a023 // 68 sw    x11, 0(x1)        'O'
40e7d733 // 6c sra   x14, x15, x14
0007e833 // 70 or    x16, x15, x0
0100a023 // 74 sw    x16, 0(x1)        'K'
0000006f // 78 jal   x0, 0             self-loop
09200493 // 7c addi  x9, x0, 0x92      subroutine
0014d493 // 80 srli  x9, x9, 1         0x49
00040067 // 84 jalr  x0, 0(x8)         return

//--- rv_core.f
rv_core_pkg.sv
rv_fetch_pair.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_data_memory.sv
rv_core.sv
rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - rv_core_pkg.sv
  - rv_fetch_pair.sv
  - rv_decode.sv
  - rv_regfile.sv
  - rv_execute.sv
  - rv_data_memory.sv
  - rv_core.sv
  - target: test
    files:
      - rv_core_tb.sv

//--- rv_core_tb.sv
/* Testbench for the dual-issue RV32I core
   Runs the program from rv_core_test.hex and checks pairing, pc flow and the output bytes */
`timescale 1ns/100ps

module rv_core_tb
  import rv_core_pkg::*;
();

  localparam int          cycle_limit   = 400;   // Program retires in well under 100 cycles
  localparam int          settle_cycles = 20;    // Cycles watched on the final self-loop
  localparam logic [63:0] expected_text = "RV32I OK";

  logic        clock;
  logic        reset_n;
  fetch_pair_t fetch;
  logic        io_valid;
  logic [7:0]  io_data;

  int          mismatches;
  int          failures;
  int          cycles;
  int          byte_count;
  int          settle;
  int          dual_count;
  logic        have_prev;
  logic        prev_io_valid;
  fetch_pair_t prev;
  word_t       expected_pc;
  logic [7:0]  expected_byte;

  rv_core DUT (.clock, .reset_n, .fetch, .io_valid, .io_data);

  initial clock = 1'b0;
  always #5 clock = ~clock;

  function automatic logic is_control_transfer(word_t inst);
    return (inst[6:0] == opc_branch) || (inst[6:0] == opc_jal) || (inst[6:0] == opc_jalr);
  endfunction

  function automatic logic is_memory_access(word_t inst);
    return (inst[6:0] == opc_load) || (inst[6:0] == opc_store);
  endfunction

  // Only formats with a real rd field count
  function automatic logic writes_register(word_t inst);
    logic [6:0] opc;
    opc = inst[6:0];
    return (inst[11:7] != 5'd0) &&
           ((opc == opc_op) || (opc == opc_op_imm) || (opc == opc_load) || (opc == opc_lui) ||
            (opc == opc_auipc) || (opc == opc_jal) || (opc == opc_jalr));
  endfunction

  function automatic logic reads_rs1(word_t inst);
    logic [6:0] opc;
    opc = inst[6:0];
    return (opc == opc_op) || (opc == opc_op_imm) || (opc == opc_load) ||
           (opc == opc_store) || (opc == opc_branch) || (opc == opc_jalr);
  endfunction

  function automatic logic reads_rs2(word_t inst);
    logic [6:0] opc;
    opc = inst[6:0];
    return (opc == opc_op) || (opc == opc_store) || (opc == opc_branch);
  endfunction

  function automatic logic may_pair(word_t first, word_t second);
    logic [4:0] rd;
    logic       hazard;
    rd     = first[11:7];
    hazard = writes_register(first) &&
             ((reads_rs1(second) && (second[19:15] == rd)) ||
              (reads_rs2(second) && (second[24:20] == rd)));
    return !is_control_transfer(first) && !is_memory_access(second) && !hazard;
  endfunction

  task automatic report_mismatch(string name, word_t expected, word_t actual);
    mismatches++;
    $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
  endtask

  task automatic report_failure(string what);
    failures++;
    $display("error at %0t: %s", $time, what);
  endtask

  // Called mid-cycle, when fetch and the io port are stable
  task automatic check_cycle();
    if (fetch.dual_issue) begin
      dual_count++;
      assert (may_pair(fetch.inst_a, fetch.inst_b))
        else report_mismatch("fetch.dual_issue", 32'd0, 32'd1);
    end else begin
      assert (fetch.inst_b == '0) else report_mismatch("fetch.inst_b", '0, fetch.inst_b);
    end
    if (have_prev) begin
      // A dropped second word is fetched next as inst_a
      if (!prev.dual_issue && !is_control_transfer(prev.inst_a)) begin
        assert (!may_pair(prev.inst_a, fetch.inst_a))
          else report_mismatch("fetch.dual_issue", 32'd1, 32'd0);
      end
      if (!is_control_transfer(prev.inst_a) && !is_control_transfer(prev.inst_b)) begin
        expected_pc = prev.pc + (prev.dual_issue ? 32'd8 : 32'd4);
        assert (fetch.pc == expected_pc) else report_mismatch("fetch.pc", expected_pc, fetch.pc);
      end
      if (settle > 0) begin
        assert (fetch.pc == prev.pc) else report_mismatch("fetch.pc", prev.pc, fetch.pc);
      end
    end
    if (io_valid) begin
      assert (!prev_io_valid) else report_failure("io_valid stayed high for more than one cycle");
      if (byte_count < 8) begin
        expected_byte = expected_text[63 - 8 * byte_count -: 8];
        assert (io_data == expected_byte) else report_mismatch("io_data", expected_byte, io_data);
        byte_count++;
      end else begin
        report_failure("io_valid pulsed after the last expected byte");
      end
    end
    if (byte_count == 8) begin
      settle++;
    end
    prev          = fetch;
    prev_io_valid = io_valid;
    have_prev     = 1'b1;
  endtask

  initial begin
    reset_n       = 1'b0;
    mismatches    = 0;
    failures      = 0;
    cycles        = 0;
    byte_count    = 0;
    settle        = 0;
    dual_count    = 0;
    have_prev     = 1'b0;
    prev_io_valid = 1'b0;
    prev          = '0;
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset_n = 1'b1;
    assert (fetch.pc == '0) else report_mismatch("fetch.pc", '0, fetch.pc);
    assert (!io_valid) else report_mismatch("io_valid", 32'd0, {31'd0, io_valid});
    check_cycle();
    while ((cycles < cycle_limit) && (settle < settle_cycles)) begin
      @(negedge clock);
      cycles++;
      check_cycle();
    end
    if (settle < settle_cycles) begin
      report_failure($sformatf("timeout after %0d cycles with %0d of 8 bytes received",
                               cycles, byte_count));
    end
    if (dual_count == 0) begin
      report_failure("no instruction pair was ever dual-issued");
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if ((mismatches + failures) == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- rv_core.sv
/* Top of the two-lane in-order RV32I core
   Wires fetch, both decode and execute lanes, writeback and the next-pc choice */
`timescale 1ns/100ps

module rv_core
  import rv_core_pkg::*;
(
  input  logic        clock,
  input  logic        reset_n,
  output fetch_pair_t fetch,
  output logic        io_valid,
  output logic [7:0]  io_data
);

  decoded_t     dec_a;
  decoded_t     dec_b;
  lane_result_t res_a;
  lane_result_t res_b;
  word_t        rs1_a;
  word_t        rs2_a;
  word_t        rs1_b;
  word_t        rs2_b;
  word_t        pc_b;
  word_t        load_data;
  word_t        wdata_a;
  word_t        wdata_b;
  word_t        next_pc;

  function automatic word_t wb_value(decoded_t dec, lane_result_t res, word_t mem_data,
                                     word_t pc);
    case (dec.wb_sel)
      wb_alu:  return res.alu_data;
      wb_mem:  return mem_data;
      wb_link: return pc + 32'd4;
      default: return '0;
    endcase
  endfunction

  rv_fetch_pair u_fetch (.clock, .reset_n, .next_pc, .fetch);

  rv_decode u_dec_a (.inst(fetch.inst_a), .dec(dec_a));
  rv_decode u_dec_b (.inst(fetch.inst_b), .dec(dec_b));

  rv_regfile u_regs (
    .clock, .dec_a, .dec_b, .wdata_a, .wdata_b,
    .rs1_a, .rs2_a, .rs1_b, .rs2_b
  );

  assign pc_b = fetch.pc + 32'd4;

  rv_execute u_exec_a (.dec(dec_a), .pc(fetch.pc), .rs1(rs1_a), .rs2(rs2_a), .result(res_a));
  rv_execute u_exec_b (.dec(dec_b), .pc(pc_b), .rs1(rs1_b), .rs2(rs2_b), .result(res_b));

  rv_data_memory u_dmem (
    .clock, .reset_n, .dec(dec_a), .addr(res_a.alu_data), .store_data(rs2_a),
    .load_data, .io_valid, .io_data
  );

  assign wdata_a = wb_value(dec_a, res_a, load_data, fetch.pc);
  assign wdata_b = wb_value(dec_b, res_b, '0, pc_b); // Loads never pair

  assign next_pc = fetch.dual_issue ? (res_b.taken ? res_b.target : fetch.pc + 32'd8)
                                    : (res_a.taken ? res_a.target : fetch.pc + 32'd4);

endmodule

//--- rv_data_memory.sv
/* Word data memory on lane one with the byte output port
   A store to the output address pulses io_valid for one cycle */
`timescale 1ns/100ps

module rv_data_memory
  import rv_core_pkg::*;
(
  input  logic       clock,
  input  logic       reset_n,
  input  decoded_t   dec,
  input  word_t      addr,
  input  word_t      store_data,
  output word_t      load_data,
  output logic       io_valid,
  output logic [7:0] io_data
);

  word_t dmem [dmem_words];
  logic [$clog2(dmem_words)-1:0] idx;
  logic io_hit;

  assign idx    = addr[$clog2(dmem_words)+1:2];
  assign io_hit = dec.mem_write && (addr == io_out_addr);

  assign load_data = dec.mem_read ? dmem[idx] : '0;

  always_ff @(posedge clock) begin
    if (dec.mem_write && !io_hit) begin
      dmem[idx] <= store_data;
    end
    if (io_hit) begin
      io_data <= store_data[7:0]; // Low byte only
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      io_valid <= 1'b0;
    end else begin
      io_valid <= io_hit;
    end
  end

  a_word_aligned: assert property (@(posedge clock) disable iff (!reset_n)
    (dec.mem_read || dec.mem_write) |-> (addr[1:0] == 2'b00));

endmodule

//--- rv_execute.sv
/* Execute stage of one lane
   Operand select, ALU and branch resolution, all combinational */
`timescale 1ns/100ps

module rv_execute
  import rv_core_pkg::*;
(
  input  decoded_t     dec,
  input  word_t        pc,
  input  word_t        rs1,
  input  word_t        rs2,
  output lane_result_t result
);

  word_t op_a;
  word_t op_b;
  word_t alu_y;
  logic  cond;

  assign op_a = dec.op1_pc  ? pc      : rs1;
  assign op_b = dec.op2_imm ? dec.imm : rs2;

  always_comb begin
    case (dec.alu_op)
      alu_add:  alu_y = op_a + op_b;
      alu_sub:  alu_y = op_a - op_b;
      alu_sll:  alu_y = op_a << op_b[4:0];
      alu_slt:  alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
      alu_sltu: alu_y = {31'b0, op_a < op_b};
      alu_xor:  alu_y = op_a ^ op_b;
      alu_srl:  alu_y = op_a >> op_b[4:0];
      alu_sra:  alu_y = $signed(op_a) >>> op_b[4:0];
      alu_or:   alu_y = op_a | op_b;
      alu_and:  alu_y = op_a & op_b;
      default:  alu_y = '0;
    endcase
  end

  // Branch condition compares the raw registers
  always_comb begin
    case (dec.funct3)
      3'b000:  cond = rs1 == rs2;
      3'b001:  cond = rs1 != rs2;
      3'b100:  cond = $signed(rs1) < $signed(rs2);
      3'b101:  cond = $signed(rs1) >= $signed(rs2);
      3'b110:  cond = rs1 < rs2;
      3'b111:  cond = rs1 >= rs2;
      default: cond = 1'b0;
    endcase
  end

  assign result.alu_data = alu_y;
  assign result.taken    = dec.is_jump || (dec.is_branch && cond);
  assign result.target   = {alu_y[xlen-1:1], 1'b0};

endmodule

//--- rv_regfile.sv
/* 32 x 32-bit register file for both lanes
   Four combinational reads and two writes at the clock edge */
`timescale 1ns/100ps

module rv_regfile
  import rv_core_pkg::*;
(
  input  logic     clock,
  input  decoded_t dec_a,
  input  decoded_t dec_b,
  input  word_t    wdata_a,
  input  word_t    wdata_b,
  output word_t    rs1_a,
  output word_t    rs2_a,
  output word_t    rs1_b,
  output word_t    rs2_b
);

  word_t regs [32];

  assign rs1_a = (dec_a.rs1 == 5'd0) ? '0 : regs[dec_a.rs1]; // x0 reads zero
  assign rs2_a = (dec_a.rs2 == 5'd0) ? '0 : regs[dec_a.rs2];
  assign rs1_b = (dec_b.rs1 == 5'd0) ? '0 : regs[dec_b.rs1];
  assign rs2_b = (dec_b.rs2 == 5'd0) ? '0 : regs[dec_b.rs2];

  always_ff @(posedge clock) begin
    if (dec_a.rf_wen) begin
      regs[dec_a.rd] <= wdata_a;
    end
    if (dec_b.rf_wen) begin
      regs[dec_b.rd] <= wdata_b; // Later in program order
    end
  end

  a_no_dual_write: assert property (@(posedge clock)
    !(dec_a.rf_wen && dec_b.rf_wen && (dec_a.rd == dec_b.rd)));

endmodule

//--- rv_decode.sv
/* Decoder for one RV32I instruction word
   Instantiated once per lane, an unknown or zero word comes out as a no-op */
`timescale 1ns/100ps

module rv_decode
  import rv_core_pkg::*;
(
  input  word_t    inst,
  output decoded_t dec
);

  opcode_t    opc;
  logic [2:0] funct3;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opc    = opcode_t'(inst[6:0]);
  assign funct3 = inst[14:12];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    dec        = '0;
    dec.rs1    = inst[19:15];
    dec.rs2    = inst[24:20];
    dec.rd     = inst[11:7];
    dec.funct3 = funct3;
    dec.alu_op = alu_add;
    dec.wb_sel = wb_alu;
    case (opc)
      opc_op: begin
        dec.alu_op = alu_op_t'({inst[30], funct3});
        dec.rf_wen = 1'b1;
      end
      opc_op_imm: begin
        // Only the right shifts use bit 30 of the immediate
        dec.alu_op  = alu_op_t'({(funct3 == 3'b101) && inst[30], funct3});
        dec.imm     = imm_i;
        dec.op2_imm = 1'b1;
        dec.rf_wen  = 1'b1;
      end
      opc_load: begin
        dec.imm      = imm_i;
        dec.op2_imm  = 1'b1;
        dec.mem_read = 1'b1;
        dec.rf_wen   = 1'b1;
        dec.wb_sel   = wb_mem;
      end
      opc_store: begin
        dec.imm       = imm_s;
        dec.op2_imm   = 1'b1;
        dec.mem_write = 1'b1;
      end
      opc_branch: begin
        dec.imm       = imm_b;
        dec.op1_pc    = 1'b1; // ALU forms the target
        dec.op2_imm   = 1'b1;
        dec.is_branch = 1'b1;
      end
      opc_lui: begin
        dec.rs1     = '0;     // x0 + imm
        dec.imm     = imm_u;
        dec.op2_imm = 1'b1;
        dec.rf_wen  = 1'b1;
      end
      opc_auipc: begin
        dec.rs1     = '0;
        dec.imm     = imm_u;
        dec.op1_pc  = 1'b1;
        dec.op2_imm = 1'b1;
        dec.rf_wen  = 1'b1;
      end
      opc_jal: begin
        dec.rs1     = '0;
        dec.imm     = imm_j;
        dec.op1_pc  = 1'b1;
        dec.op2_imm = 1'b1;
        dec.is_jump = 1'b1;
        dec.rf_wen  = 1'b1;
        dec.wb_sel  = wb_link;
      end
      opc_jalr: begin
        dec.imm     = imm_i;
        dec.op2_imm = 1'b1;
        dec.is_jump = 1'b1;
        dec.rf_wen  = 1'b1;
        dec.wb_sel  = wb_link;
      end
      opc_system, opc_misc_mem: begin
        dec.rf_wen = 1'b0;    // ECALL, EBREAK and FENCE retire as no-ops
      end
      default: begin
        dec.rf_wen = 1'b0;
      end
    endcase
    if (dec.rd == 5'd0) begin
      dec.rf_wen = 1'b0;
    end
  end

endmodule

//--- rv_fetch_pair.sv
/* Program counter, instruction memory and the dual-issue pairing check
   Presents two adjacent words per cycle and flags whether the second may issue */
`timescale 1ns/100ps

module rv_fetch_pair
  import rv_core_pkg::*;
(
  input  logic        clock,
  input  logic        reset_n,
  input  word_t       next_pc,
  output fetch_pair_t fetch
);

  word_t pc;
  word_t imem [imem_words];
  word_t word_a;
  word_t word_b;
  logic [$clog2(imem_words)-1:0] idx_a;
  logic [$clog2(imem_words)-1:0] idx_b;
  opcode_t opc_a;
  opcode_t opc_b;
  reg_addr_t rd_a;
  logic ctrl_a;
  logic mem_b;
  logic writes_a;
  logic reads_rs1_b;
  logic reads_rs2_b;
  logic raw_hazard;
  logic dual;

  initial $readmemh(imem_file, imem);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

  assign idx_a  = pc[$clog2(imem_words)+1:2];
  assign idx_b  = idx_a + 1'b1;          // Wraps at end of memory
  assign word_a = imem[idx_a];
  assign word_b = imem[idx_b];

  assign opc_a = opcode_t'(word_a[6:0]);
  assign opc_b = opcode_t'(word_b[6:0]);
  assign rd_a  = word_a[11:7];

  assign ctrl_a = (opc_a == opc_branch) || (opc_a == opc_jal) || (opc_a == opc_jalr);
  assign mem_b  = (opc_b == opc_load) || (opc_b == opc_store); // Memory is on lane one only

  assign writes_a = (rd_a != 5'd0) &&
                    ((opc_a == opc_op) || (opc_a == opc_op_imm) || (opc_a == opc_load) ||
                     (opc_a == opc_lui) || (opc_a == opc_auipc) || (opc_a == opc_jal) ||
                     (opc_a == opc_jalr));
  assign reads_rs1_b = (opc_b == opc_op) || (opc_b == opc_op_imm) || (opc_b == opc_load) ||
                       (opc_b == opc_store) || (opc_b == opc_branch) || (opc_b == opc_jalr);
  assign reads_rs2_b = (opc_b == opc_op) || (opc_b == opc_store) || (opc_b == opc_branch);

  assign raw_hazard = writes_a &&
                      ((reads_rs1_b && (word_b[19:15] == rd_a)) ||
                       (reads_rs2_b && (word_b[24:20] == rd_a)));

  assign dual = !ctrl_a && !mem_b && !raw_hazard;

  assign fetch.pc         = pc;
  assign fetch.inst_a     = word_a;
  assign fetch.inst_b     = dual ? word_b : '0; // Zero word decodes as a no-op
  assign fetch.dual_issue = dual;

  a_pc_aligned: assert property (@(posedge clock) disable iff (!reset_n)
    pc[1:0] == 2'b00);

endmodule

//--- rv_core_pkg.sv
/* Shared widths, encodings and decoded-instruction types of the dual-issue RV32I core
   Every RTL module of the core imports this package */
package rv_core_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  localparam int    imem_words  = 1024;
  localparam int    dmem_words  = 1024;
  localparam word_t io_out_addr = 32'h0000_fff0; // Byte output port
  localparam string imem_file   = "rv_core_test.hex";

  typedef enum logic [6:0] {
    opc_op       = 7'b0110011,
    opc_op_imm   = 7'b0010011,
    opc_load     = 7'b0000011,
    opc_store    = 7'b0100011,
    opc_branch   = 7'b1100011,
    opc_lui      = 7'b0110111,
    opc_auipc    = 7'b0010111,
    opc_jal      = 7'b1101111,
    opc_jalr     = 7'b1100111,
    opc_system   = 7'b1110011,
    opc_misc_mem = 7'b0001111
  } opcode_t;

  // Encoded as {funct7[5], funct3}
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sub  = 4'b1000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_srl  = 4'b0101,
    alu_sra  = 4'b1101,
    alu_or   = 4'b0110,
    alu_and  = 4'b0111
  } alu_op_t;

  typedef enum logic [1:0] {
    wb_alu  = 2'd0,
    wb_mem  = 2'd1,
    wb_link = 2'd2
  } wb_sel_t;

  typedef struct packed {
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    word_t      imm;
    alu_op_t    alu_op;
    logic [2:0] funct3;
    logic       op1_pc;    // Operand A is the lane pc
    logic       op2_imm;   // Operand B is the immediate
    logic       is_branch;
    logic       is_jump;
    logic       mem_read;
    logic       mem_write;
    logic       rf_wen;
    wb_sel_t    wb_sel;
  } decoded_t;

  typedef struct packed {
    word_t pc;
    word_t inst_a;      // Word at pc
    word_t inst_b;      // Word at pc + 4, zero when not issued
    logic  dual_issue;
  } fetch_pair_t;

  typedef struct packed {
    word_t alu_data;
    logic  taken;
    word_t target;      // alu_data with bit 0 cleared
  } lane_result_t;

endpackage
